// File: src/pipe_ctrl_pkg.sv
//////////////////////////////////////////////////
// Shared types for the four-stage pipeline controller
// Widths are fixed here; no module parameters
//////////////////////////////////////////////////

package pipe_ctrl_pkg;

  // Meaningful widths
  typedef logic [4:0] exc_cause_t;
  typedef logic [4:0] irq_id_t;
  // Bit 5 is the interrupt flag, bits 4:0 the code
  typedef logic [5:0] csr_cause_t;

  // Synchronous exception codes
  localparam exc_cause_t EXC_CAUSE_INSTR_BUS_FAULT = 5'h01;
  localparam exc_cause_t EXC_CAUSE_ILLEGAL_INSN    = 5'h02;
  localparam exc_cause_t EXC_CAUSE_BREAKPOINT      = 5'h03;
  localparam exc_cause_t EXC_CAUSE_ECALL_MMODE     = 5'h0B;

  // Main controller states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    FUNCTIONAL,
    SLEEP,
    DEBUG_TAKEN
  } ctrl_state_e;

  // Debug status, one-hot
  typedef enum logic [2:0] {
    HAVERESET = 3'b001,
    RUNNING   = 3'b010,
    HALTED    = 3'b100
  } debug_state_e;

  // Fetch PC source
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_EXCEPTION,
    PC_DRET
  } pc_mux_e;

  // Exception vector select
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBE
  } exc_pc_e;

  //////////////////////////////////////////////////
  // Pipeline register status
  //////////////////////////////////////////////////
  typedef struct packed {
    logic instr_valid;
  } if_id_status_t;

  typedef struct packed {
    logic instr_valid;
    logic branch_in_ex;
  } id_ex_status_t;

  typedef struct packed {
    logic instr_valid;
    logic lsu_en;
    logic bus_err;
    logic illegal_insn;
    logic ecall_insn;
    logic ebrk_insn;
    logic wfi_insn;
    logic dret_insn;
  } ex_wb_status_t;

  // Qualified control-flow events, one per stage
  typedef struct packed {
    logic       jump_id;
    logic       branch_ex;
    logic       exception_wb;
    exc_cause_t exc_cause;
    logic       wfi_wb;
    logic       ebreak_wb;
    logic       dret_wb;
  } ctrl_events_t;

  // Request permissions
  typedef struct packed {
    logic pending_debug;
    logic debug_allowed;
    logic interrupt_allowed;
  } ctrl_permit_t;

  //////////////////////////////////////////////////
  // Controller outputs
  //////////////////////////////////////////////////
  typedef struct packed {
    logic       instr_req;
    logic       ctrl_busy;
    logic       pc_set;
    pc_mux_e    pc_mux;
    exc_pc_e    exc_pc_mux;
    logic       halt_if;
    logic       halt_id;
    logic       halt_ex;
    logic       halt_wb;
    logic       kill_if;
    logic       kill_id;
    logic       kill_ex;
    logic       kill_wb;
    logic       csr_save_if;
    logic       csr_save_id;
    logic       csr_save_ex;
    logic       csr_save_wb;
    logic       csr_save_cause;
    csr_cause_t csr_cause;
    logic       csr_restore_dret;
    logic       debug_csr_save;
    logic       irq_ack;
    irq_id_t    irq_id;
    logic       debug_mode;
    logic       debug_havereset;
    logic       debug_running;
    logic       debug_halted;
  } ctrl_fsm_t;

endpackage

// File: src/ctrl_event_decode.sv
//////////////////////////////////////////////////
// Zero-latency event decode; every flag is qualified by its stage valid
//////////////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_event_decode import pipe_ctrl_pkg::*; (
  input  if_id_status_t if_id_i,
  input  id_ex_status_t id_ex_i,
  input  ex_wb_status_t ex_wb_i,
  input  logic          jump_id_i,
  input  logic          jr_stall_i,
  input  logic          branch_decision_i,
  output ctrl_events_t  events_o
);

  logic wb_valid;

  assign wb_valid = ex_wb_i.instr_valid;

  always_comb begin
    // ID stage
    // Jump only once the jr operand hazard has cleared
    events_o.jump_id   = jump_id_i && if_id_i.instr_valid && !jr_stall_i;

    // EX stage
    events_o.branch_ex = id_ex_i.branch_in_ex && id_ex_i.instr_valid &&
                         branch_decision_i;

    // WB stage
    events_o.exception_wb = wb_valid && (ex_wb_i.bus_err || ex_wb_i.illegal_insn ||
                                         ex_wb_i.ecall_insn || ex_wb_i.ebrk_insn);
    events_o.wfi_wb    = wb_valid && ex_wb_i.wfi_insn;
    events_o.ebreak_wb = wb_valid && ex_wb_i.ebrk_insn;
    events_o.dret_wb   = wb_valid && ex_wb_i.dret_insn;

    // Cause priority
    // Bus error wins, ebreak is the fall-through
    if (ex_wb_i.bus_err) begin
      events_o.exc_cause = EXC_CAUSE_INSTR_BUS_FAULT;
    end else if (ex_wb_i.illegal_insn) begin
      events_o.exc_cause = EXC_CAUSE_ILLEGAL_INSN;
    end else if (ex_wb_i.ecall_insn) begin
      events_o.exc_cause = EXC_CAUSE_ECALL_MMODE;
    end else begin
      events_o.exc_cause = EXC_CAUSE_BREAKPOINT;
    end
  end

endmodule

// File: src/ctrl_permit_track.sv
//////////////////////////////////////////////////
// Both flags act one cycle after their event
// debug_req_i may be a single-cycle pulse
//////////////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_permit_track import pipe_ctrl_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          data_req_i,
  input  logic          ex_valid_i,
  input  logic          wb_ready_i,
  input  logic          debug_req_i,
  input  logic          debug_mode_i,
  input  ex_wb_status_t ex_wb_i,
  input  ctrl_events_t  events_i,
  output ctrl_permit_t  permit_o
);

  // Data request issued, instruction not yet in WB
  logic data_req_q;
  // Sticky debug request
  logic debug_req_q;
  logic lsu_in_wb;
  logic lsu_quiet;

  assign lsu_in_wb = ex_wb_i.lsu_en && ex_wb_i.instr_valid;
  assign lsu_quiet = !lsu_in_wb && !data_req_q;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      data_req_q <= 1'b0;
    end else if (data_req_i && !(ex_valid_i && wb_ready_i)) begin
      data_req_q <= 1'b1;
    end else if (ex_valid_i && wb_ready_i) begin
      data_req_q <= 1'b0;
    end
  end

  // Held until the core is in debug mode
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      debug_req_q <= 1'b0;
    end else if (debug_req_i) begin
      debug_req_q <= 1'b1;
    end else if (debug_mode_i) begin
      debug_req_q <= 1'b0;
    end
  end

  always_comb begin
    permit_o.pending_debug     = (debug_req_i || debug_req_q) && !debug_mode_i;
    // Debug kills WB, so a bus access there must finish first
    permit_o.debug_allowed     = lsu_quiet;
    // A faulting WB instruction made no bus access
    permit_o.interrupt_allowed = (lsu_quiet || events_i.exception_wb) && !debug_mode_i;
  end

  // Flag stays low across a handover from EX to WB
  a_no_req_on_handover : assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid_i && wb_ready_i) |=> !data_req_q);

endmodule

// File: src/ctrl_main_fsm.sv
//////////////////////////////////////////////////
// Outputs are combinational from inputs and state
// Status bits of ctrl_o are left at 0 here
//////////////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_main_fsm import pipe_ctrl_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          fetch_enable_i,
  input  ctrl_events_t  events_i,
  input  ctrl_permit_t  permit_i,
  input  if_id_status_t if_id_i,
  input  id_ex_status_t id_ex_i,
  input  ex_wb_status_t ex_wb_i,
  input  logic          irq_req_i,
  input  logic          irq_wake_i,
  input  irq_id_t       irq_id_i,
  output ctrl_fsm_t     ctrl_o,
  output logic          debug_mode_o,
  output logic          debug_mode_next_o,
  output logic          boot_next_o
);

  ctrl_state_e state_q, state_d;
  logic        debug_mode_q, debug_mode_d;
  logic        irq_pending;
  logic        wake;
  // One-hot PC save select, oldest valid stage
  logic        save_wb, save_ex, save_id, save_if;

  // No interrupts while in debug mode
  assign irq_pending = irq_req_i && !debug_mode_q;
  assign wake        = irq_wake_i || permit_i.pending_debug;

  assign save_wb = ex_wb_i.instr_valid;
  assign save_ex = !ex_wb_i.instr_valid && id_ex_i.instr_valid;
  assign save_id = !ex_wb_i.instr_valid && !id_ex_i.instr_valid && if_id_i.instr_valid;
  // IF PC always points at the next instruction to issue
  assign save_if = !(ex_wb_i.instr_valid || id_ex_i.instr_valid || if_id_i.instr_valid);

  //////////////////////////////////////////////////
  // Next state and control decode
  //////////////////////////////////////////////////
  always_comb begin
    // Defaults
    ctrl_o            = '0;
    ctrl_o.instr_req  = 1'b1;
    ctrl_o.ctrl_busy  = 1'b1;
    ctrl_o.pc_mux     = PC_BOOT;
    ctrl_o.exc_pc_mux = EXC_PC_IRQ;
    ctrl_o.debug_mode = debug_mode_q;
    state_d           = state_q;
    debug_mode_d      = debug_mode_q;

    unique case (state_q)
      RESET: begin
        ctrl_o.instr_req = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end
      // Single-cycle boot redirect
      BOOT_SET: begin
        ctrl_o.pc_set = 1'b1;
        ctrl_o.pc_mux = PC_BOOT;
        state_d       = FUNCTIONAL;
      end
      FUNCTIONAL: begin
        if (permit_i.pending_debug) begin
          if (permit_i.debug_allowed) begin
            // Freeze the pipe, redirect next cycle
            ctrl_o.halt_if = 1'b1;
            ctrl_o.halt_id = 1'b1;
            ctrl_o.halt_ex = 1'b1;
            ctrl_o.halt_wb = 1'b1;
            state_d        = DEBUG_TAKEN;
          end else begin
            // Stop issue, retry each cycle
            ctrl_o.halt_id = 1'b1;
          end
        end else if (irq_pending) begin
          if (permit_i.interrupt_allowed) begin
            ctrl_o.kill_if        = 1'b1;
            ctrl_o.kill_id        = 1'b1;
            ctrl_o.kill_ex        = 1'b1;
            ctrl_o.kill_wb        = 1'b1;
            ctrl_o.pc_set         = 1'b1;
            ctrl_o.pc_mux         = PC_EXCEPTION;
            ctrl_o.exc_pc_mux     = EXC_PC_IRQ;
            ctrl_o.irq_ack        = 1'b1;
            ctrl_o.irq_id         = irq_id_i;
            ctrl_o.csr_save_cause = 1'b1;
            ctrl_o.csr_cause      = {1'b1, irq_id_i};
            ctrl_o.csr_save_wb    = save_wb;
            ctrl_o.csr_save_ex    = save_ex;
            ctrl_o.csr_save_id    = save_id;
            ctrl_o.csr_save_if    = save_if;
          end else begin
            ctrl_o.halt_id = 1'b1;
          end
        end else if (events_i.exception_wb) begin
          ctrl_o.kill_if        = 1'b1;
          ctrl_o.kill_id        = 1'b1;
          ctrl_o.kill_ex        = 1'b1;
          ctrl_o.kill_wb        = 1'b1;
          ctrl_o.pc_set         = 1'b1;
          ctrl_o.pc_mux         = PC_EXCEPTION;
          ctrl_o.exc_pc_mux     = debug_mode_q ? EXC_PC_DBE : EXC_PC_EXCEPTION;
          ctrl_o.csr_save_wb    = 1'b1;
          // mcause untouched inside debug mode
          ctrl_o.csr_save_cause = !debug_mode_q;
          ctrl_o.csr_cause      = {1'b0, events_i.exc_cause};
        end else if (events_i.wfi_wb) begin
          // EX and WB keep draining into sleep
          if (!debug_mode_q) begin
            ctrl_o.halt_if   = 1'b1;
            ctrl_o.halt_id   = 1'b1;
            ctrl_o.instr_req = 1'b0;
            state_d          = SLEEP;
          end
        end else if (events_i.dret_wb) begin
          ctrl_o.kill_if          = 1'b1;
          ctrl_o.kill_id          = 1'b1;
          ctrl_o.kill_ex          = 1'b1;
          ctrl_o.pc_set           = 1'b1;
          ctrl_o.pc_mux           = PC_DRET;
          ctrl_o.csr_restore_dret = 1'b1;
          debug_mode_d            = 1'b0;
        end else if (events_i.branch_ex) begin
          ctrl_o.kill_if = 1'b1;
          ctrl_o.kill_id = 1'b1;
          ctrl_o.pc_set  = 1'b1;
          ctrl_o.pc_mux  = PC_BRANCH;
        end else if (events_i.jump_id) begin
          ctrl_o.kill_if = 1'b1;
          ctrl_o.pc_set  = 1'b1;
          ctrl_o.pc_mux  = PC_JUMP;
        end
      end
      SLEEP: begin
        ctrl_o.ctrl_busy = 1'b0;
        ctrl_o.instr_req = 1'b0;
        // Halting WB holds the whole pipe
        ctrl_o.halt_wb   = 1'b1;
        if (wake) begin
          state_d = FUNCTIONAL;
        end
      end
      DEBUG_TAKEN: begin
        ctrl_o.kill_if        = 1'b1;
        ctrl_o.kill_id        = 1'b1;
        ctrl_o.kill_ex        = 1'b1;
        ctrl_o.kill_wb        = 1'b1;
        ctrl_o.pc_set         = 1'b1;
        ctrl_o.pc_mux         = PC_EXCEPTION;
        ctrl_o.exc_pc_mux     = EXC_PC_DBD;
        ctrl_o.debug_csr_save = 1'b1;
        // dpc from the oldest valid stage
        ctrl_o.csr_save_wb    = save_wb;
        ctrl_o.csr_save_ex    = save_ex;
        ctrl_o.csr_save_id    = save_id;
        ctrl_o.csr_save_if    = save_if;
        debug_mode_d          = 1'b1;
        state_d               = FUNCTIONAL;
      end
      default: begin
        ctrl_o.instr_req = 1'b0;
        state_d          = RESET;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= RESET;
      debug_mode_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      debug_mode_q <= debug_mode_d;
    end
  end

  assign debug_mode_o      = debug_mode_q;
  assign debug_mode_next_o = debug_mode_d;
  assign boot_next_o       = (state_d == BOOT_SET);

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////
  a_no_redirect_idle : assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_o.pc_set |-> !(state_q inside {RESET, SLEEP}));

  // Source drops its request once it sees the acknowledge
  a_irq_ack_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_o.irq_ack |=> !ctrl_o.irq_ack);

endmodule

// File: src/debug_status_fsm.sv
//////////////////////////////////////////////////
// Debug status, updated on the same edge as debug_mode
//////////////////////////////////////////////////
`timescale 1ns/1ps

module debug_status_fsm import pipe_ctrl_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic debug_mode_next_i,
  input  logic boot_next_i,
  output logic havereset_o,
  output logic running_o,
  output logic halted_o
);

  debug_state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // Debug entry wins over boot
      HAVERESET: begin
        if (debug_mode_next_i) begin
          state_d = HALTED;
        end else if (boot_next_i) begin
          state_d = RUNNING;
        end
      end
      RUNNING: begin
        if (debug_mode_next_i) begin
          state_d = HALTED;
        end
      end
      HALTED: begin
        if (!debug_mode_next_i) begin
          state_d = RUNNING;
        end
      end
      default: state_d = HAVERESET;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= HAVERESET;
    end else begin
      state_q <= state_d;
    end
  end

  assign havereset_o = (state_q == HAVERESET);
  assign running_o   = (state_q == RUNNING);
  assign halted_o    = (state_q == HALTED);

  a_status_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot({havereset_o, running_o, halted_o}));

endmodule

// File: src/pipe_ctrl_top.sv
//////////////////////////////////////////////////
// Pipeline controller top; single clock domain
// irq_req_i must be held until irq_ack_o is seen
//////////////////////////////////////////////////
`timescale 1ns/1ps

module pipe_ctrl_top import pipe_ctrl_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          fetch_enable_i,
  // Interrupt source
  input  logic          irq_req_i,
  input  irq_id_t       irq_id_i,
  input  logic          irq_wake_i,
  input  logic          debug_req_i,
  // EX and LSU
  input  logic          data_req_i,
  input  logic          ex_valid_i,
  input  logic          wb_ready_i,
  // Decoder and ALU
  input  logic          jump_id_i,
  input  logic          jr_stall_i,
  input  logic          branch_decision_i,
  // Pipeline registers
  input  if_id_status_t if_id_i,
  input  id_ex_status_t id_ex_i,
  input  ex_wb_status_t ex_wb_i,
  output ctrl_fsm_t     ctrl_o,
  output logic          irq_ack_o
);

  ctrl_events_t events;
  ctrl_permit_t permit;
  ctrl_fsm_t    fsm_ctrl;
  logic         debug_mode;
  logic         debug_mode_next;
  logic         boot_next;
  logic         havereset;
  logic         running;
  logic         halted;

  ctrl_event_decode u_event_decode (
    .if_id_i           (if_id_i),
    .id_ex_i           (id_ex_i),
    .ex_wb_i           (ex_wb_i),
    .jump_id_i         (jump_id_i),
    .jr_stall_i        (jr_stall_i),
    .branch_decision_i (branch_decision_i),
    .events_o          (events)
  );

  ctrl_permit_track u_permit_track (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_req_i   (data_req_i),
    .ex_valid_i   (ex_valid_i),
    .wb_ready_i   (wb_ready_i),
    .debug_req_i  (debug_req_i),
    .debug_mode_i (debug_mode),
    .ex_wb_i      (ex_wb_i),
    .events_i     (events),
    .permit_o     (permit)
  );

  ctrl_main_fsm u_main_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .events_i          (events),
    .permit_i          (permit),
    .if_id_i           (if_id_i),
    .id_ex_i           (id_ex_i),
    .ex_wb_i           (ex_wb_i),
    .irq_req_i         (irq_req_i),
    .irq_wake_i        (irq_wake_i),
    .irq_id_i          (irq_id_i),
    .ctrl_o            (fsm_ctrl),
    .debug_mode_o      (debug_mode),
    .debug_mode_next_o (debug_mode_next),
    .boot_next_o       (boot_next)
  );

  debug_status_fsm u_debug_status (
    .clk               (clk),
    .rst_n             (rst_n),
    .debug_mode_next_i (debug_mode_next),
    .boot_next_i       (boot_next),
    .havereset_o       (havereset),
    .running_o         (running),
    .halted_o          (halted)
  );

  // Merge debug status into the control struct
  always_comb begin
    ctrl_o                 = fsm_ctrl;
    ctrl_o.debug_havereset = havereset;
    ctrl_o.debug_running   = running;
    ctrl_o.debug_halted    = halted;
  end

  assign irq_ack_o = fsm_ctrl.irq_ack;

endmodule

// File: verification/pipe_ctrl_model.svh
//////////////////////////////////////////////////
// Cycle model of the controller, included inside the testbench module
// Needs the DUT input signals declared before the include
//////////////////////////////////////////////////
`ifndef PIPE_CTRL_MODEL_SVH
`define PIPE_CTRL_MODEL_SVH

// Model state committed on each rising edge
ctrl_state_e  m_state;
ctrl_state_e  m_state_nxt;
logic         m_dbg_mode;
logic         m_dbg_mode_nxt;
logic         m_data_req;
logic         m_dbg_req;
debug_state_e m_status;
ctrl_fsm_t    exp_ctrl;

task automatic reset_model();
  m_state    = RESET;
  m_dbg_mode = 1'b0;
  m_data_req = 1'b0;
  m_dbg_req  = 1'b0;
  m_status   = HAVERESET;
endtask

// Kill the n youngest stages starting at IF
task automatic kill_front(int n);
  exp_ctrl.kill_if = (n >= 1);
  exp_ctrl.kill_id = (n >= 2);
  exp_ctrl.kill_ex = (n >= 3);
  exp_ctrl.kill_wb = (n >= 4);
endtask

task automatic redirect(pc_mux_e mux, exc_pc_e vec);
  exp_ctrl.pc_set     = 1'b1;
  exp_ctrl.pc_mux     = mux;
  exp_ctrl.exc_pc_mux = vec;
endtask

// PC saved from the oldest valid stage or IF when all are empty
task automatic save_oldest();
  if (ex_wb_i.instr_valid) exp_ctrl.csr_save_wb = 1'b1;
  else if (id_ex_i.instr_valid) exp_ctrl.csr_save_ex = 1'b1;
  else if (if_id_i.instr_valid) exp_ctrl.csr_save_id = 1'b1;
  else exp_ctrl.csr_save_if = 1'b1;
endtask

// Expected outputs and next state from current state and inputs
task automatic predict_outputs();
  logic       wb_v;
  logic       exc;
  logic       quiet;
  logic       dbg_pend;
  exc_cause_t cause;
  wb_v     = ex_wb_i.instr_valid;
  exc      = wb_v && (ex_wb_i.bus_err || ex_wb_i.illegal_insn ||
                      ex_wb_i.ecall_insn || ex_wb_i.ebrk_insn);
  // Cause priority is bus error, illegal, ecall, breakpoint
  if (ex_wb_i.bus_err) cause = EXC_CAUSE_INSTR_BUS_FAULT;
  else if (ex_wb_i.illegal_insn) cause = EXC_CAUSE_ILLEGAL_INSN;
  else if (ex_wb_i.ecall_insn) cause = EXC_CAUSE_ECALL_MMODE;
  else cause = EXC_CAUSE_BREAKPOINT;
  quiet    = !(wb_v && ex_wb_i.lsu_en) && !m_data_req;
  dbg_pend = (debug_req_i || m_dbg_req) && !m_dbg_mode;

  exp_ctrl                 = '0;
  exp_ctrl.instr_req       = !(m_state inside {RESET, SLEEP});
  exp_ctrl.ctrl_busy       = (m_state != SLEEP);
  exp_ctrl.debug_mode      = m_dbg_mode;
  exp_ctrl.debug_havereset = (m_status == HAVERESET);
  exp_ctrl.debug_running   = (m_status == RUNNING);
  exp_ctrl.debug_halted    = (m_status == HALTED);
  m_state_nxt              = m_state;
  m_dbg_mode_nxt           = m_dbg_mode;

  case (m_state)
    RESET: if (fetch_enable_i) m_state_nxt = BOOT_SET;
    BOOT_SET: begin
      redirect(PC_BOOT, EXC_PC_EXCEPTION);
      m_state_nxt = FUNCTIONAL;
    end
    SLEEP: begin
      exp_ctrl.halt_wb = 1'b1;
      if (irq_wake_i || dbg_pend) m_state_nxt = FUNCTIONAL;
    end
    DEBUG_TAKEN: begin
      kill_front(4);
      redirect(PC_EXCEPTION, EXC_PC_DBD);
      exp_ctrl.debug_csr_save = 1'b1;
      save_oldest();
      m_dbg_mode_nxt = 1'b1;
      m_state_nxt    = FUNCTIONAL;
    end
    default: begin
      if (dbg_pend) begin
        // Hold issue and retry until permitted
        exp_ctrl.halt_id = 1'b1;
        if (quiet) begin
          exp_ctrl.halt_if = 1'b1;
          exp_ctrl.halt_ex = 1'b1;
          exp_ctrl.halt_wb = 1'b1;
          m_state_nxt      = DEBUG_TAKEN;
        end
      end else if (irq_req_i && !m_dbg_mode) begin
        if (quiet || exc) begin
          kill_front(4);
          redirect(PC_EXCEPTION, EXC_PC_IRQ);
          exp_ctrl.irq_ack        = 1'b1;
          exp_ctrl.irq_id         = irq_id_i;
          exp_ctrl.csr_save_cause = 1'b1;
          exp_ctrl.csr_cause      = {1'b1, irq_id_i};
          save_oldest();
        end else begin
          exp_ctrl.halt_id = 1'b1;
        end
      end else if (exc) begin
        kill_front(4);
        redirect(PC_EXCEPTION, m_dbg_mode ? EXC_PC_DBE : EXC_PC_EXCEPTION);
        exp_ctrl.csr_save_wb    = 1'b1;
        exp_ctrl.csr_save_cause = !m_dbg_mode;
        exp_ctrl.csr_cause      = {1'b0, cause};
      end else if (wb_v && ex_wb_i.wfi_insn) begin
        if (!m_dbg_mode) begin
          exp_ctrl.halt_if   = 1'b1;
          exp_ctrl.halt_id   = 1'b1;
          exp_ctrl.instr_req = 1'b0;
          m_state_nxt        = SLEEP;
        end
      end else if (wb_v && ex_wb_i.dret_insn) begin
        kill_front(3);
        redirect(PC_DRET, EXC_PC_EXCEPTION);
        exp_ctrl.csr_restore_dret = 1'b1;
        m_dbg_mode_nxt            = 1'b0;
      end else if (id_ex_i.instr_valid && id_ex_i.branch_in_ex && branch_decision_i) begin
        kill_front(2);
        redirect(PC_BRANCH, EXC_PC_EXCEPTION);
      end else if (if_id_i.instr_valid && jump_id_i && !jr_stall_i) begin
        kill_front(1);
        redirect(PC_JUMP, EXC_PC_EXCEPTION);
      end
    end
  endcase
endtask

// Flags, state and debug status at the rising edge
task automatic advance_model();
  logic handover;
  handover = ex_valid_i && wb_ready_i;
  if (data_req_i && !handover) m_data_req = 1'b1;
  else if (handover) m_data_req = 1'b0;
  if (debug_req_i) m_dbg_req = 1'b1;
  else if (m_dbg_mode) m_dbg_req = 1'b0;
  if (m_status == HAVERESET) begin
    if (m_dbg_mode_nxt) m_status = HALTED;
    else if (m_state_nxt == BOOT_SET) m_status = RUNNING;
  end else begin
    m_status = m_dbg_mode_nxt ? HALTED : RUNNING;
  end
  m_state    = m_state_nxt;
  m_dbg_mode = m_dbg_mode_nxt;
endtask

`endif

// File: verification/pipe_ctrl_tb.sv
//////////////////////////////////////////////////
// Random and directed checks of the controller against a cycle model
// Inputs change 1 ns after the rising edge and outputs are sampled 3 ns after it
//////////////////////////////////////////////////
`timescale 1ns/1ps

module pipe_ctrl_tb import pipe_ctrl_pkg::*; ();

  logic          clk;
  logic          rst_n;
  logic          fetch_enable_i;
  logic          irq_req_i;
  irq_id_t       irq_id_i;
  logic          irq_wake_i;
  logic          debug_req_i;
  logic          data_req_i;
  logic          ex_valid_i;
  logic          wb_ready_i;
  logic          jump_id_i;
  logic          jr_stall_i;
  logic          branch_decision_i;
  if_id_status_t if_id_i;
  id_ex_status_t id_ex_i;
  ex_wb_status_t ex_wb_i;
  ctrl_fsm_t     ctrl_o;
  logic          irq_ack_o;

  string test_name = "reset";
  logic  ack_last  = 1'b0;
  int    boot_count = 0;
  int    ack_count  = 0;
  int    exc_count  = 0;
  int    dbd_count  = 0;

  `include "pipe_ctrl_model.svh"

  pipe_ctrl_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(string field, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR [%s] %s: expected %0h, actual %0h", test_name, field, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "Output mismatch");
    end
  endtask

  task automatic timeout_fail(string what);
    $display("Timeout in test %s: %s", test_name, what);
    $display("STATUS: FAIL");
    $fatal(1, "Wait limit reached");
  endtask

  task automatic compare_outputs();
    ctrl_fsm_t e;
    e = exp_ctrl;
    check_value("instr_req", e.instr_req, ctrl_o.instr_req);
    check_value("ctrl_busy", e.ctrl_busy, ctrl_o.ctrl_busy);
    check_value("pc_set", e.pc_set, ctrl_o.pc_set);
    // Mux selects only matter with a redirect
    if (e.pc_set) check_value("pc_mux", e.pc_mux, ctrl_o.pc_mux);
    if (e.pc_set && e.pc_mux == PC_EXCEPTION)
      check_value("exc_pc_mux", e.exc_pc_mux, ctrl_o.exc_pc_mux);
    check_value("halts", {e.halt_if, e.halt_id, e.halt_ex, e.halt_wb},
                {ctrl_o.halt_if, ctrl_o.halt_id, ctrl_o.halt_ex, ctrl_o.halt_wb});
    check_value("kills", {e.kill_if, e.kill_id, e.kill_ex, e.kill_wb},
                {ctrl_o.kill_if, ctrl_o.kill_id, ctrl_o.kill_ex, ctrl_o.kill_wb});
    check_value("csr_save", {e.csr_save_if, e.csr_save_id, e.csr_save_ex, e.csr_save_wb,
                e.csr_save_cause}, {ctrl_o.csr_save_if, ctrl_o.csr_save_id,
                ctrl_o.csr_save_ex, ctrl_o.csr_save_wb, ctrl_o.csr_save_cause});
    if (e.csr_save_cause) check_value("csr_cause", e.csr_cause, ctrl_o.csr_cause);
    check_value("csr_restore_dret", e.csr_restore_dret, ctrl_o.csr_restore_dret);
    check_value("debug_csr_save", e.debug_csr_save, ctrl_o.debug_csr_save);
    check_value("irq_ack", {2{e.irq_ack}}, {irq_ack_o, ctrl_o.irq_ack});
    if (e.irq_ack) check_value("irq_id", e.irq_id, ctrl_o.irq_id);
    check_value("debug_mode", e.debug_mode, ctrl_o.debug_mode);
    check_value("debug_status", {e.debug_havereset, e.debug_running, e.debug_halted},
                {ctrl_o.debug_havereset, ctrl_o.debug_running, ctrl_o.debug_halted});
  endtask

  // Check before the edge and advance the model after it
  task automatic run_cycle();
    #2;
    predict_outputs();
    compare_outputs();
    ack_last = irq_ack_o;
    if (ctrl_o.pc_set && ctrl_o.pc_mux == PC_BOOT) boot_count++;
    if (irq_ack_o) ack_count++;
    if (ctrl_o.pc_set && ctrl_o.pc_mux == PC_EXCEPTION) begin
      if (ctrl_o.exc_pc_mux == EXC_PC_EXCEPTION) exc_count++;
      if (ctrl_o.exc_pc_mux == EXC_PC_DBD) dbd_count++;
    end
    @(posedge clk);
    advance_model();
    #1;
  endtask

  function automatic logic rand_bit(int unsigned pct);
    return ($urandom % 100) < pct;
  endfunction

  task automatic clear_inputs();
    if_id_i           = '0;
    id_ex_i           = '0;
    ex_wb_i           = '0;
    irq_req_i         = 1'b0;
    irq_id_i          = '0;
    irq_wake_i        = 1'b0;
    debug_req_i       = 1'b0;
    data_req_i        = 1'b0;
    // Handover clears any issued data request
    ex_valid_i        = 1'b1;
    wb_ready_i        = 1'b1;
    jump_id_i         = 1'b0;
    jr_stall_i        = 1'b0;
    branch_decision_i = 1'b0;
  endtask

  // Back to FUNCTIONAL from any random end state
  task automatic settle();
    clear_inputs();
    irq_wake_i = 1'b1;
    repeat (2) run_cycle();
    irq_wake_i = 1'b0;
  endtask

  task automatic drive_random(int unsigned exc_pct, logic use_irq);
    if_id_i.instr_valid    = rand_bit(70);
    id_ex_i                = {rand_bit(70), rand_bit(40)};
    ex_wb_i.instr_valid    = rand_bit(70);
    ex_wb_i.lsu_en         = rand_bit(30);
    ex_wb_i.bus_err        = rand_bit(exc_pct);
    ex_wb_i.illegal_insn   = rand_bit(exc_pct);
    ex_wb_i.ecall_insn     = rand_bit(exc_pct);
    ex_wb_i.ebrk_insn      = rand_bit(exc_pct);
    ex_wb_i.wfi_insn       = rand_bit(8);
    ex_wb_i.dret_insn      = rand_bit(8);
    jump_id_i              = rand_bit(30);
    jr_stall_i             = rand_bit(20);
    branch_decision_i      = rand_bit(50);
    data_req_i             = rand_bit(30);
    ex_valid_i             = rand_bit(60);
    wb_ready_i             = rand_bit(60);
    irq_wake_i             = rand_bit(25);
    // Source holds its request and id until it sees the acknowledge
    if (use_irq) begin
      if (irq_req_i && ack_last) begin
        irq_req_i = 1'b0;
      end else if (!irq_req_i && rand_bit(25)) begin
        irq_req_i = 1'b1;
        irq_id_i  = irq_id_t'($urandom);
      end
    end
  endtask

  initial begin
    int count;
    void'($urandom(32'h40fc5a5d));
    clear_inputs();
    fetch_enable_i = 1'b0;
    rst_n          = 1'b0;
    reset_model();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    //////////////////////////////////////////////////
    // Boot
    test_name = "boot";
    repeat (4) run_cycle();
    check_value("havereset", 1'b1, ctrl_o.debug_havereset);
    fetch_enable_i = 1'b1;
    count = 0;
    while (boot_count == 0) begin
      if (count == 10) timeout_fail("no boot redirect after fetch enable");
      run_cycle();
      count++;
    end
    run_cycle();
    check_value("boot redirects", 1, boot_count);
    check_value("running", 1'b1, ctrl_o.debug_running);

    // Random redirects without interrupts or debug
    test_name = "redirect";
    repeat (400) begin
      drive_random(6, 1'b0);
      run_cycle();
    end
    check_value("exceptions taken", 1'b1, exc_count != 0);

    test_name = "irq";
    settle();
    repeat (400) begin
      drive_random(3, 1'b1);
      run_cycle();
    end
    check_value("irq acks seen", 1'b1, ack_count != 0);

    //////////////////////////////////////////////////
    // Sleep and wake
    test_name = "sleep";
    settle();
    ex_wb_i.instr_valid = 1'b1;
    ex_wb_i.wfi_insn    = 1'b1;
    run_cycle();
    ex_wb_i = '0;
    repeat (3) run_cycle();
    check_value("asleep busy", 1'b0, ctrl_o.ctrl_busy);
    irq_wake_i = 1'b1;
    run_cycle();
    irq_wake_i = 1'b0;
    check_value("awake busy", 1'b1, ctrl_o.ctrl_busy);
    run_cycle();

    //////////////////////////////////////////////////
    // Debug entry held off by an LSU instruction in WB
    test_name = "debug";
    settle();
    dbd_count           = 0;
    ex_wb_i.instr_valid = 1'b1;
    ex_wb_i.lsu_en      = 1'b1;
    debug_req_i         = 1'b1;
    run_cycle();
    debug_req_i = 1'b0;
    repeat (3) run_cycle();
    check_value("held off", 1'b0, ctrl_o.debug_halted);
    ex_wb_i = '0;
    count   = 0;
    while (!ctrl_o.debug_halted) begin
      if (count == 10) timeout_fail("debug entry never completed");
      run_cycle();
      count++;
    end
    check_value("debug vector redirects", 1, dbd_count);
    // Exception in debug mode followed by dret
    ex_wb_i.instr_valid  = 1'b1;
    ex_wb_i.illegal_insn = 1'b1;
    run_cycle();
    ex_wb_i             = '0;
    ex_wb_i.instr_valid = 1'b1;
    ex_wb_i.dret_insn   = 1'b1;
    run_cycle();
    ex_wb_i = '0;
    count   = 0;
    while (!ctrl_o.debug_running) begin
      if (count == 10) timeout_fail("no return to running after dret");
      run_cycle();
      count++;
    end
    run_cycle();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: build.f
+incdir+verification
src/pipe_ctrl_pkg.sv
src/ctrl_event_decode.sv
src/ctrl_permit_track.sv
src/ctrl_main_fsm.sv
src/debug_status_fsm.sv
src/pipe_ctrl_top.sv
verification/pipe_ctrl_tb.sv

// File: Bender.yml
package:
  name: pipe_ctrl

sources:
  - src/pipe_ctrl_pkg.sv
  - src/ctrl_event_decode.sv
  - src/ctrl_permit_track.sv
  - src/ctrl_main_fsm.sv
  - src/debug_status_fsm.sv
  - src/pipe_ctrl_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/pipe_ctrl_tb.sv
